// File: hdl/uart_pkg.sv
package uart_pkg;

	localparam int OVERSAMPLE   = 16; // ticks per bit
	localparam int START_SAMPLE = 7; // mid-point of the start bit
	localparam int DIV_W        = 16;

	typedef enum logic [1:0] {
		REG_CTRL   = 2'd0,
		REG_DIV    = 2'd1,
		REG_DATA   = 2'd2,
		REG_STATUS = 2'd3
	} reg_addr_e;

	typedef enum logic [1:0] {
		RX_IDLE = 2'd0,
		RX_DATA = 2'd1,
		RX_STOP = 2'd2
	} rx_state_e;

	typedef enum logic [1:0] {
		TX_IDLE  = 2'd0,
		TX_START = 2'd1,
		TX_DATA  = 2'd2,
		TX_STOP  = 2'd3
	} tx_state_e;

	typedef struct packed {
		logic             rx_en;
		logic             tx_en;
		logic [DIV_W-1:0] divisor;
	} uart_cfg_t;

	// first member lands in the msb, so rx_valid ends up in bit 0
	typedef struct packed {
		logic tx_busy;
		logic frame_err;
		logic overrun;
		logic rx_valid;
	} uart_status_t;

endpackage

// File: hdl/uart_cfg_regs.sv
`timescale 1ns/10ps

module uart_cfg_regs (
	input  logic                clk_i,
	input  logic                rst_i,
	input  uart_pkg::reg_addr_e addr_i,
	input  logic                wr_i,
	input  logic                rd_i,
	input  logic [15:0]         wdata_i,
	output logic [15:0]         rdata_o,
	output uart_pkg::uart_cfg_t cfg_o,
	output logic                div_wr_o,
	output logic                tx_start_o,
	output logic [7:0]          tx_byte_o,
	input  logic                tx_busy_i,
	input  logic                rx_done_i,
	input  logic [7:0]          rx_byte_i,
	input  logic                rx_ferr_i
);
	import uart_pkg::*;

	logic         rx_valid_q;
	logic         overrun_q;
	logic         ferr_q;
	logic [7:0]   rx_data_q;
	logic         data_rd;
	logic         rx_ok;
	uart_status_t status;

	assign data_rd = rd_i && (addr_i == REG_DATA);
	assign rx_ok   = rx_done_i && !rx_ferr_i;

	always_comb begin
		status.rx_valid  = rx_valid_q;
		status.overrun   = overrun_q;
		status.frame_err = ferr_q;
		status.tx_busy   = tx_busy_i;
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			cfg_o      <= '0;
			div_wr_o   <= 1'b0;
			tx_start_o <= 1'b0;
			rx_valid_q <= 1'b0;
			overrun_q  <= 1'b0;
			ferr_q     <= 1'b0;
		end else begin
			div_wr_o   <= wr_i && (addr_i == REG_DIV); // one cycle late so the new divisor is in place
			tx_start_o <= wr_i && (addr_i == REG_DATA) && !tx_busy_i && !tx_start_o;
			if (wr_i && (addr_i == REG_CTRL)) begin
				cfg_o.rx_en <= wdata_i[0];
				cfg_o.tx_en <= wdata_i[1];
			end
			if (wr_i && (addr_i == REG_DIV))
				cfg_o.divisor <= wdata_i;
			if (wr_i && (addr_i == REG_STATUS)) begin // clear sticky flags
				overrun_q <= 1'b0;
				ferr_q    <= 1'b0;
			end
			if (data_rd)
				rx_valid_q <= 1'b0;
			if (rx_ok) begin
				rx_valid_q <= 1'b1;
				if (rx_valid_q && !data_rd)
					overrun_q <= 1'b1; // old byte never read
			end
			if (rx_done_i && rx_ferr_i)
				ferr_q <= 1'b1;
		end
	end

	always_ff @(posedge clk_i) begin
		if (wr_i && (addr_i == REG_DATA) && !tx_busy_i && !tx_start_o)
			tx_byte_o <= wdata_i[7:0];
		if (rx_ok)
			rx_data_q <= rx_byte_i;
	end

	always_comb begin
		case (addr_i)
			REG_CTRL:   rdata_o = {14'd0, cfg_o.tx_en, cfg_o.rx_en};
			REG_DIV:    rdata_o = cfg_o.divisor;
			REG_DATA:   rdata_o = {8'd0, rx_data_q};
			REG_STATUS: rdata_o = {12'd0, status};
			default:    rdata_o = 16'd0;
		endcase
	end

endmodule

// File: hdl/uart_baud_gen.sv
`timescale 1ns/10ps

module uart_baud_gen (
	input  logic                clk_i,
	input  logic                rst_i,
	input  uart_pkg::uart_cfg_t cfg_i,
	input  logic                div_wr_i,
	output logic                tick_o
);
	import uart_pkg::*;

	logic [DIV_W-1:0] cnt_q;

	// one tick every divisor+1 clocks
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			cnt_q  <= '0;
			tick_o <= 1'b0;
		end else if (div_wr_i) begin
			cnt_q  <= cfg_i.divisor; // restart at the new rate
			tick_o <= 1'b0;
		end else if (cnt_q == '0) begin
			cnt_q  <= cfg_i.divisor;
			tick_o <= 1'b1;
		end else begin
			cnt_q  <= cnt_q - 1'b1;
			tick_o <= 1'b0;
		end
	end

endmodule

// File: hdl/uart_rx.sv
`timescale 1ns/10ps

module uart_rx (
	input  logic       clk_i,
	input  logic       rst_i,
	input  logic       rx_en_i,
	input  logic       tick_i,
	input  logic       rx_i,
	output logic [7:0] byte_o,
	output logic       done_o,
	output logic       ferr_o
);
	import uart_pkg::*;

	rx_state_e                       state_q;
	rx_state_e                       state_d;
	logic [$clog2(OVERSAMPLE)-1:0] cnt_q;
	logic [$clog2(OVERSAMPLE)-1:0] cnt_d;
	logic [2:0]                      bit_q;
	logic [2:0]                      bit_d;
	logic [7:0]                      shift_q;
	logic [7:0]                      shift_d;
	logic                            done_d;
	logic                            rx_meta;
	logic                            rx_s;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rx_meta <= 1'b1; // line idles high
			rx_s    <= 1'b1;
		end else begin
			rx_meta <= rx_i;
			rx_s    <= rx_meta;
		end
	end

	always_comb begin
		state_d = state_q;
		cnt_d   = cnt_q;
		bit_d   = bit_q;
		shift_d = shift_q;
		done_d  = 1'b0;
		if (rx_en_i && tick_i) begin // state frozen while disabled
			case (state_q)
				RX_IDLE: begin
					if (rx_s) begin
						cnt_d = '0; // glitch restarts the count
					end else if (int'(cnt_q) == START_SAMPLE) begin
						state_d = RX_DATA;
						cnt_d   = '0;
						bit_d   = '0;
					end else begin
						cnt_d = cnt_q + 1'b1;
					end
				end
				RX_DATA: begin
					if (int'(cnt_q) == OVERSAMPLE - 1) begin
						cnt_d   = '0;
						shift_d = {rx_s, shift_q[7:1]}; // lsb first
						bit_d   = bit_q + 1'b1;
						if (&bit_q)
							state_d = RX_STOP;
					end else begin
						cnt_d = cnt_q + 1'b1;
					end
				end
				RX_STOP: begin
					if (int'(cnt_q) == OVERSAMPLE - 1) begin
						done_d  = 1'b1;
						cnt_d   = '0;
						state_d = RX_IDLE;
					end else begin
						cnt_d = cnt_q + 1'b1;
					end
				end
				default: begin
					state_d = RX_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q <= RX_IDLE;
			cnt_q   <= '0;
			bit_q   <= '0;
			done_o  <= 1'b0;
		end else begin
			state_q <= state_d;
			cnt_q   <= cnt_d;
			bit_q   <= bit_d;
			done_o  <= done_d;
		end
	end

	always_ff @(posedge clk_i) begin
		shift_q <= shift_d;
		if (done_d) begin
			byte_o <= shift_q;
			ferr_o <= ~rx_s; // stop bit must be high
		end
	end

endmodule

// File: hdl/uart_tx.sv
`timescale 1ns/10ps

module uart_tx (
	input  logic       clk_i,
	input  logic       rst_i,
	input  logic       tx_en_i,
	input  logic       tick_i,
	input  logic       start_i,
	input  logic [7:0] byte_i,
	output logic       tx_o,
	output logic       busy_o
);
	import uart_pkg::*;

	tx_state_e                       state_q;
	tx_state_e                       state_d;
	logic [$clog2(OVERSAMPLE)-1:0] cnt_q;
	logic [$clog2(OVERSAMPLE)-1:0] cnt_d;
	logic [2:0]                      bit_q;
	logic [2:0]                      bit_d;
	logic [7:0]                      shift_q;
	logic [7:0]                      shift_d;
	logic                            bit_end;
	logic                            tx_d;

	assign bit_end = tick_i && (int'(cnt_q) == OVERSAMPLE - 1);
	assign busy_o  = (state_q != TX_IDLE);

	always_comb begin
		state_d = state_q;
		cnt_d   = cnt_q;
		bit_d   = bit_q;
		shift_d = shift_q;
		if (!tx_en_i) begin
			state_d = TX_IDLE; // held idle while disabled
		end else begin
			if (tick_i && state_q != TX_IDLE)
				cnt_d = cnt_q + 1'b1; // wraps to 0 at the bit end
			case (state_q)
				TX_IDLE: begin
					if (start_i) begin
						state_d = TX_START;
						shift_d = byte_i;
						cnt_d   = '0;
						bit_d   = '0;
					end
				end
				TX_START: begin
					if (bit_end)
						state_d = TX_DATA;
				end
				TX_DATA: begin
					if (bit_end) begin
						shift_d = {1'b0, shift_q[7:1]};
						bit_d   = bit_q + 1'b1;
						if (&bit_q)
							state_d = TX_STOP;
					end
				end
				TX_STOP: begin
					if (bit_end)
						state_d = TX_IDLE;
				end
				default: begin
					state_d = TX_IDLE;
				end
			endcase
		end
	end

	always_comb begin
		case (state_d)
			TX_START: tx_d = 1'b0;
			TX_DATA:  tx_d = shift_d[0];
			default:  tx_d = 1'b1; // idle and stop
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q <= TX_IDLE;
			cnt_q   <= '0;
			bit_q   <= '0;
			tx_o    <= 1'b1;
		end else begin
			state_q <= state_d;
			cnt_q   <= cnt_d;
			bit_q   <= bit_d;
			tx_o    <= tx_d;
		end
	end

	always_ff @(posedge clk_i) begin
		shift_q <= shift_d;
	end

endmodule

// File: hdl/uart_top.sv
`timescale 1ns/10ps

module uart_top (
	input  logic                clk_i,
	input  logic                rst_i,
	input  uart_pkg::reg_addr_e addr_i,
	input  logic                wr_i,
	input  logic                rd_i,
	input  logic [15:0]         wdata_i,
	output logic [15:0]         rdata_o,
	input  logic                rx_i,
	output logic                tx_o
);
	import uart_pkg::*;

	uart_cfg_t  cfg;
	logic       div_wr;
	logic       tick;
	logic       tx_start;
	logic [7:0] tx_byte;
	logic       tx_busy;
	logic       rx_done;
	logic [7:0] rx_byte;
	logic       rx_ferr;

	uart_cfg_regs u_regs (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.addr_i     (addr_i),
		.wr_i       (wr_i),
		.rd_i       (rd_i),
		.wdata_i    (wdata_i),
		.rdata_o    (rdata_o),
		.cfg_o      (cfg),
		.div_wr_o   (div_wr),
		.tx_start_o (tx_start),
		.tx_byte_o  (tx_byte),
		.tx_busy_i  (tx_busy),
		.rx_done_i  (rx_done),
		.rx_byte_i  (rx_byte),
		.rx_ferr_i  (rx_ferr)
	);

	uart_baud_gen u_baud (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.cfg_i    (cfg),
		.div_wr_i (div_wr),
		.tick_o   (tick)
	);

	uart_rx u_rx (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.rx_en_i (cfg.rx_en),
		.tick_i  (tick),
		.rx_i    (rx_i),
		.byte_o  (rx_byte),
		.done_o  (rx_done),
		.ferr_o  (rx_ferr)
	);

	uart_tx u_tx (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.tx_en_i (cfg.tx_en),
		.tick_i  (tick),
		.start_i (tx_start),
		.byte_i  (tx_byte),
		.tx_o    (tx_o),
		.busy_o  (tx_busy)
	);

endmodule

// File: verif/uart_sva.sv
`timescale 1ns/10ps

module uart_sva (
	input logic                       clk_i,
	input logic                       rst_i,
	input logic                       tick_i,
	input logic                       rx_done_i,
	input logic                       tx_busy_i,
	input logic                       tx_line_i,
	input logic [uart_pkg::DIV_W-1:0] divisor_i
);

	int fail_count = 0; // assertion failures so far

	rx_done_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
		rx_done_i |=> !rx_done_i)
		else begin
			$error("rx_done stayed high for more than one cycle");
			fail_count++;
		end

	tx_idle_high: assert property (@(posedge clk_i) disable iff (rst_i)
		!tx_busy_i |-> tx_line_i)
		else begin
			$error("tx line low while the transmitter is idle");
			fail_count++;
		end

	// with divisor 0 the tick is high on every clock
	tick_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
		(tick_i && divisor_i != '0) |=> !tick_i)
		else begin
			$error("tick stayed high for more than one cycle");
			fail_count++;
		end

endmodule

bind uart_top uart_sva u_sva (
	.clk_i     (clk_i),
	.rst_i     (rst_i),
	.tick_i    (tick),
	.rx_done_i (rx_done),
	.tx_busy_i (tx_busy),
	.tx_line_i (tx_o),
	.divisor_i (cfg.divisor)
);

// File: verif/uart_tb.sv
`timescale 1ns/10ps

module uart_tb;
	import uart_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int LOOP_POLLS = 3000; // covers a frame at divisor 10
	localparam int IDLE_POLLS = 300;

	logic        clk;
	logic        rst;
	reg_addr_e   addr;
	logic        wr;
	logic        rd;
	logic [15:0] wdata;
	logic [15:0] rdata;
	logic        rx_line;
	logic        tx_line;
	logic        loopback;
	logic        drv_line;
	int          cur_div;
	int          errors;
	int          failed_tests;
	int          test_start_errors;

	assign rx_line = loopback ? tx_line : drv_line; // line select

	uart_top DUT (
		.clk_i   (clk),
		.rst_i   (rst),
		.addr_i  (addr),
		.wr_i    (wr),
		.rd_i    (rd),
		.wdata_i (wdata),
		.rdata_o (rdata),
		.rx_i    (rx_line),
		.tx_o    (tx_line)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#5000000;
		$display("run stopped by the watchdog, a wait never ended");
		$display("Simulation failed");
		$finish;
	end

	// immediate checks plus the bound assertion failures
	function automatic int error_total();
		return errors + DUT.u_sva.fail_count;
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic reg_write(input reg_addr_e a, input logic [15:0] d);
		next_cycle();
		addr  = a;
		wdata = d;
		wr    = 1'b1;
		next_cycle();
		wr = 1'b0;
	endtask

	task automatic reg_read(input reg_addr_e a, output logic [15:0] d);
		next_cycle();
		addr = a;
		rd   = 1'b1;
		#8;
		d = rdata; // combinational read, settled mid-cycle
		next_cycle();
		rd = 1'b0;
	endtask

	task automatic check_eq(input string name, input logic [15:0] got, input logic [15:0] exp);
		assert (got === exp)
		else begin
			$display("ERR %s: got 0x%04h, expected 0x%04h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		assert (cond)
		else begin
			$display("%s", what);
			errors++;
		end
	endtask

	// polls REG_STATUS until one bit reaches the level
	task automatic wait_flag(input int idx, input logic level, input int max_polls,
			output bit seen);
		logic [15:0] st;
		int          n;
		seen = 1'b0;
		n    = 0;
		while (!seen && n < max_polls) begin
			reg_read(REG_STATUS, st);
			seen = (st[idx] === level);
			n++;
		end
	endtask

	task automatic send_byte(input logic [7:0] b);
		bit seen;
		wait_flag(3, 1'b0, LOOP_POLLS, seen);
		check_true(seen, "transmitter still busy at the timeout");
		reg_write(REG_DATA, {8'd0, b});
	endtask

	task automatic loop_byte(input logic [7:0] b);
		bit          seen;
		logic [15:0] d;
		send_byte(b);
		wait_flag(0, 1'b1, LOOP_POLLS, seen);
		check_true(seen, "no byte received before the timeout");
		reg_read(REG_DATA, d);
		check_eq("rx_data", d, {8'd0, b});
		reg_read(REG_STATUS, d);
		check_eq("rx_valid", d & 16'h1, 16'h0);
	endtask

	task automatic hold_line(input logic v, input int clks);
		drv_line = v;
		repeat (clks) next_cycle();
	endtask

	// a bad stop bit is low past its mid-point and then high
	task automatic drive_frame(input logic [7:0] b, input bit good_stop);
		int tick_clks;
		int bit_clks;
		tick_clks = cur_div + 1;
		bit_clks  = OVERSAMPLE * tick_clks;
		next_cycle();
		hold_line(1'b0, bit_clks);
		for (int i = 0; i < 8; i++)
			hold_line(b[i], bit_clks);
		if (good_stop) begin
			hold_line(1'b1, bit_clks);
		end else begin
			hold_line(1'b0, 10 * tick_clks);
			hold_line(1'b1, 6 * tick_clks);
		end
		hold_line(1'b1, 2 * bit_clks);
	endtask

	task automatic end_test(input string name);
		if (error_total() == test_start_errors) begin
			$display("test %s: ok", name);
		end else begin
			failed_tests++;
			$display("test %s: FAILED with %0d errors", name,
				error_total() - test_start_errors);
		end
		test_start_errors = error_total();
	endtask

	initial begin
		logic [15:0] d;
		logic [7:0]  b;
		logic [7:0]  first_b;
		bit          seen;
		rst               = 1'b1;
		addr              = REG_CTRL;
		wr                = 1'b0;
		rd                = 1'b0;
		wdata             = 16'd0;
		loopback          = 1'b0;
		drv_line          = 1'b1;
		cur_div           = 0;
		errors            = 0;
		failed_tests      = 0;
		test_start_errors = 0;
		void'($urandom(3764));
		repeat (5) @(posedge clk);
		#2;
		rst = 1'b0;

		reg_read(REG_STATUS, d);
		check_eq("status", d, 16'h0);
		check_eq("tx_o", {15'd0, tx_line}, 16'h1);
		reg_read(REG_CTRL, d);
		check_eq("ctrl", d, 16'h0);
		end_test("1 reset values");

		reg_write(REG_DIV, 16'd3);
		cur_div  = 3;
		loopback = 1'b1;
		reg_write(REG_CTRL, 16'h3); // rx_en and tx_en
		for (int i = 0; i < 8; i++) begin
			b = $urandom();
			loop_byte(b);
		end
		end_test("2 loopback divisor 3");

		reg_write(REG_DIV, 16'd10);
		cur_div = 10;
		for (int i = 0; i < 3; i++) begin
			b = $urandom();
			loop_byte(b);
		end
		end_test("3 loopback divisor 10");

		first_b = $urandom();
		b       = $urandom();
		if (b == first_b)
			b = ~first_b;
		send_byte(first_b);
		wait_flag(0, 1'b1, LOOP_POLLS, seen);
		check_true(seen, "first byte not received before the timeout");
		send_byte(b);
		wait_flag(1, 1'b1, LOOP_POLLS, seen);
		check_true(seen, "overrun not flagged before the timeout");
		reg_read(REG_STATUS, d);
		check_eq("overrun", (d >> 1) & 16'h1, 16'h1);
		reg_read(REG_DATA, d);
		check_eq("rx_data", d, {8'd0, b});
		reg_write(REG_STATUS, 16'h0);
		reg_read(REG_STATUS, d);
		check_eq("overrun", (d >> 1) & 16'h1, 16'h0);
		end_test("4 overrun");

		wait_flag(3, 1'b0, LOOP_POLLS, seen);
		check_true(seen, "transmitter still busy at the timeout");
		loopback = 1'b0;
		b        = $urandom();
		drive_frame(b, 1'b1);
		wait_flag(0, 1'b1, IDLE_POLLS, seen);
		check_true(seen, "driven byte not received before the timeout");
		drive_frame(~b, 1'b0);
		wait_flag(2, 1'b1, IDLE_POLLS, seen);
		check_true(seen, "frame_err not flagged before the timeout");
		reg_read(REG_STATUS, d);
		check_eq("frame_err", (d >> 2) & 16'h1, 16'h1);
		check_eq("rx_valid", d & 16'h1, 16'h1);
		reg_read(REG_DATA, d);
		check_eq("rx_data", d, {8'd0, b});
		reg_write(REG_STATUS, 16'h0);
		reg_read(REG_STATUS, d);
		check_eq("status", d, 16'h0);
		end_test("5 framing error");

		reg_write(REG_CTRL, 16'h2); // tx only
		b = $urandom();
		drive_frame(b, 1'b1);
		wait_flag(0, 1'b1, IDLE_POLLS, seen);
		check_true(!seen, "rx_valid rose while the receiver was disabled");
		end_test("6 receiver disabled");

		$display("tests run: 6, failed tests: %0d, errors: %0d", failed_tests, error_total());
		if (error_total() == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: tb.f
hdl/uart_pkg.sv
hdl/uart_cfg_regs.sv
hdl/uart_baud_gen.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/uart_top.sv
verif/uart_sva.sv
verif/uart_tb.sv

// File: Bender.yml
package:
  name: uart_periph

sources:
  - hdl/uart_pkg.sv
  - hdl/uart_cfg_regs.sv
  - hdl/uart_baud_gen.sv
  - hdl/uart_rx.sv
  - hdl/uart_tx.sv
  - hdl/uart_top.sv
  - target: test
    files:
      - verif/uart_sva.sv
      - verif/uart_tb.sv
